// ==== tb/pu_testdata.txt ====
# columns: test <name> <stall 0|1> | inst <hex word> | wb <register> <hex value> | end
# wb lines list the expected write-backs of the test in program order
test reset 0
inst 7C000378
wb 0 00000000
inst 7C210378
wb 1 00000000
inst 7CE70378
wb 7 00000000
inst 7FFF0378
wb 31 00000000
end
test immediates 0
inst 38201234
wb 1 00001234
inst 3840FFFE
wb 2 FFFFFFFE
inst 3C608001
wb 3 80010000
inst 60248000
wb 4 00009234
inst 38A27FFF
wb 5 00007FFD
inst 3CC5FFFF
wb 6 FFFF7FFD
end
test xo_ops 0
inst 7D011214
wb 8 00001232
inst 7D211850
wb 9 8000EDCC
inst 7C8A1B78
wb 10 80019234
inst 7CCB1038
wb 11 FFFF7FFC
inst 7CAC3278
wb 12 FFFF0000
end
test dependent 0
inst 39A00005
wb 13 00000005
inst 7DCD6A14
wb 14 0000000A
inst 7DED7050
wb 15 00000005
inst 39EF0003
wb 15 00000008
inst 7DF07278
wb 16 00000002
inst 7E117B78
wb 17 0000000A
inst 7E328038
wb 18 00000002
end
test dropped 0
inst 3A600001
wb 19 00000001
inst 60000000
inst 7E939A14
wb 20 00000002
inst 82940004
inst 7C000000
inst 3AB40010
wb 21 00000012
inst 60000000
inst 60000000
inst 7EB6A278
wb 22 00000010
end
test stalls 1
inst 39A00005
wb 13 00000005
inst 7DCD6A14
wb 14 0000000A
inst 7DED7050
wb 15 00000005
inst 39EF0003
wb 15 00000008
inst 7DF07278
wb 16 00000002
inst 7E117B78
wb 17 0000000A
inst 7E328038
wb 18 00000002
end

// ==== files.f ====
+incdir+hdl
hdl/pu_types_pkg.sv
hdl/pu_inst_pkg.sv
hdl/register_file.sv
hdl/decode.sv
hdl/alu_stage.sv
hdl/pu_core.sv
tb/pu_core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f files.f --top-module pu_core_tb -o pu_core_sim
./obj_dir/pu_core_sim 2>&1 | tee sim.log

if grep -q "Verification failed" sim.log; then
	exit 1
fi
exit 0

// ==== tb/pu_core_tb.sv ====
// reads tb/pu_testdata.txt relative to the working directory, so run from the project root
`timescale 1ns/1ps

module pu_core_tb
	import pu_types_pkg::*;
();

	localparam int WAIT_LIMIT = 200;

	logic     clk;
	logic     rst_n;
	logic     inst_valid;
	inst_t    inst;
	logic     inst_ready;
	logic     wb_ready;
	logic     wb_valid;
	gpr_sel_t wb_dest;
	word_t    wb_data;

	// expected write-backs in program order, consumed by the monitor
	gpr_sel_t exp_dest_q[$];
	word_t    exp_data_q[$];
	// instructions of the test being parsed
	inst_t    pend_q[$];

	integer seed = 32'h25af_c553;
	bit     stall_en;
	bit     timed_out;
	int     errors;
	int     wb_errors;
	int     checks;
	int     tests;

	pu_core u_pu_core (
		.clk        (clk),
		.rst_n      (rst_n),
		.inst_valid (inst_valid),
		.inst       (inst),
		.inst_ready (inst_ready),
		.wb_ready   (wb_ready),
		.wb_valid   (wb_valid),
		.wb_dest    (wb_dest),
		.wb_data    (wb_data)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// random back-pressure, about one cycle in four, only where a test enables it
	initial begin
		wb_ready = 1'b1;
		forever begin
			@(posedge clk);
			if (stall_en && rst_n) begin
				wb_ready <= ($random(seed) & 3) != 0;
			end else begin
				wb_ready <= 1'b1;
			end
		end
	end

	task automatic check_writeback();
		gpr_sel_t exp_dest;
		word_t    exp_data;
		assert (exp_data_q.size() != 0) else begin
			$display("unexpected write-back to r%0d at %0t ns", wb_dest, $time);
			wb_errors++;
		end
		if (exp_data_q.size() != 0) begin
			exp_dest = exp_dest_q.pop_front();
			exp_data = exp_data_q.pop_front();
			checks++;
			assert (wb_dest == exp_dest) else begin
				$display("error at %0t ns: wb_dest is %0d, expected %0d",
					$time, wb_dest, exp_dest);
				wb_errors++;
			end
			assert (wb_data == exp_data) else begin
				$display("error at %0t ns: wb_data is %h, expected %h",
					$time, wb_data, exp_data);
				wb_errors++;
			end
		end
	endtask

	// every consumed write-back is compared with the head of the queue
	always @(posedge clk) begin
		if (rst_n) begin
			assert (wb_ready || !inst_ready) else begin
				$display("error at %0t ns: inst_ready is %b, expected 0 while wb_ready is low",
					$time, inst_ready);
				wb_errors++;
			end
			if (wb_valid && wb_ready) begin
				check_writeback();
			end
		end
	end

	task automatic send_inst(input inst_t word);
		int waited;
		bit taken;
		waited = 0;
		taken  = 1'b0;
		inst_valid <= 1'b1;
		inst       <= word;
		while (!taken && waited < WAIT_LIMIT) begin
			@(posedge clk);
			taken = inst_ready;
			waited++;
		end
		if (!taken) begin
			$display("timeout: instruction %h not accepted within %0d cycles", word, WAIT_LIMIT);
			timed_out = 1'b1;
		end
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (exp_data_q.size() != 0 && waited < WAIT_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (exp_data_q.size() != 0) begin
			$display("timeout: %0d expected write-backs never arrived", exp_data_q.size());
			timed_out = 1'b1;
		end
	endtask

	task automatic run_test(input string name);
		int first_check;
		int first_err;
		first_check = checks;
		first_err   = errors + wb_errors;
		@(posedge clk);
		while (pend_q.size() != 0 && !timed_out) begin
			send_inst(pend_q.pop_front());
		end
		inst_valid <= 1'b0;
		if (!timed_out) begin
			wait_drain();
		end
		stall_en = 1'b0;
		// idle gap so a stray write-back from a dropped instruction still shows up
		repeat (4) @(negedge clk);
		tests++;
		$display("test %s: %0d write-backs checked, %0d errors", name,
			checks - first_check, errors + wb_errors - first_err);
	endtask

	task automatic run_file();
		int          fd;
		int          n;
		int          stall_flag;
		int          dest;
		logic [31:0] value;
		string       line;
		string       kind;
		string       name;
		fd = $fopen("tb/pu_testdata.txt", "r");
		if (fd == 0) begin
			$display("could not open tb/pu_testdata.txt");
			errors++;
			return;
		end
		while (!timed_out && $fgets(line, fd) != 0) begin
			n = $sscanf(line, "%s", kind);
			if (n != 1 || kind == "#") begin
				continue;
			end
			if (kind == "test") begin
				n = $sscanf(line, "%s %s %d", kind, name, stall_flag);
				stall_en = (stall_flag != 0);
				pend_q.delete();
			end else if (kind == "inst") begin
				n = $sscanf(line, "%s %h", kind, value);
				pend_q.push_back(value);
			end else if (kind == "wb") begin
				n = $sscanf(line, "%s %d %h", kind, dest, value);
				exp_dest_q.push_back(gpr_sel_t'(dest));
				exp_data_q.push_back(value);
			end else if (kind == "end") begin
				run_test(name);
			end else begin
				$display("unknown line in test data: %s", line);
				errors++;
			end
		end
		$fclose(fd);
	endtask

	initial begin
		rst_n      = 1'b0;
		inst_valid = 1'b0;
		inst       = '0;
		stall_en   = 1'b0;
		timed_out  = 1'b0;
		errors     = 0;
		tests      = 0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		assert (!wb_valid) else begin
			$display("error at %0t ns: wb_valid is %b, expected 0", $time, wb_valid);
			errors++;
		end
		assert (inst_ready == wb_ready) else begin
			$display("error at %0t ns: inst_ready is %b, expected %b",
				$time, inst_ready, wb_ready);
			errors++;
		end
		run_file();
		$display("%0d tests, %0d write-backs checked, %0d errors",
			tests, checks, errors + wb_errors);
		if (errors + wb_errors == 0 && !timed_out && tests != 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// ==== hdl/pu_core.sv ====
// no fetch unit; the instruction source must hold inst while inst_valid is high and inst_ready low
`timescale 1ns/1ps
`include "pu_macros.svh"

module pu_core
	import pu_types_pkg::*;
	import pu_inst_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  logic     inst_valid,
	input  inst_t    inst,
	output logic     inst_ready,
	input  logic     wb_ready,
	output logic     wb_valid,
	output gpr_sel_t wb_dest,
	output word_t    wb_data
);

	logic     stall;
	gpr_sel_t gpr_sel_a;
	gpr_sel_t gpr_sel_b;
	word_t    gpr_a;
	word_t    gpr_b;
	logic     gpr_we;
	word_t    alu_result;
	logic     ex_valid;
	alu_op_t  ex_op;
	word_t    ex_a;
	word_t    ex_b;
	gpr_sel_t ex_dest;

	// one global stall for every pipeline register
	assign stall = !wb_ready;

	decode u_decode (
		.clk        (clk),
		.rst_n      (rst_n),
		.inst_valid (inst_valid),
		.inst       (inst),
		.inst_ready (inst_ready),
		.stall      (stall),
		.gpr_sel_a  (gpr_sel_a),
		.gpr_sel_b  (gpr_sel_b),
		.gpr_a      (gpr_a),
		.gpr_b      (gpr_b),
		.alu_result (alu_result),
		.ex_valid   (ex_valid),
		.ex_op      (ex_op),
		.ex_a       (ex_a),
		.ex_b       (ex_b),
		.ex_dest    (ex_dest)
	);

	alu_stage u_alu_stage (
		.clk        (clk),
		.rst_n      (rst_n),
		.stall      (stall),
		.ex_valid   (ex_valid),
		.ex_op      (ex_op),
		.ex_a       (ex_a),
		.ex_b       (ex_b),
		.ex_dest    (ex_dest),
		.alu_result (alu_result),
		.wb_valid   (wb_valid),
		.wb_dest    (wb_dest),
		.wb_data    (wb_data),
		.gpr_we     (gpr_we)
	);

	// write port comes straight from the write-back register
	register_file u_register_file (
		.clk       (clk),
		.rst_n     (rst_n),
		.gpr_sel_a (gpr_sel_a),
		.gpr_sel_b (gpr_sel_b),
		.gpr_a     (gpr_a),
		.gpr_b     (gpr_b),
		.gpr_we    (gpr_we),
		.gpr_dest  (wb_dest),
		.gpr_data  (wb_data)
	);

endmodule

// ==== hdl/alu_stage.sv ====
// no carry or overflow outputs; the result register holds until consumed by wb_ready
`timescale 1ns/1ps
`include "pu_macros.svh"

module alu_stage
	import pu_types_pkg::*;
	import pu_inst_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  logic     stall,
	input  logic     ex_valid,
	input  alu_op_t  ex_op,
	input  word_t    ex_a,
	input  word_t    ex_b,
	input  gpr_sel_t ex_dest,
	output word_t    alu_result,
	output logic     wb_valid,
	output gpr_sel_t wb_dest,
	output word_t    wb_data,
	output logic     gpr_we
);

	// combinational result, also used by decode for forwarding
	always_comb begin
		case (ex_op)
			alu_add:  alu_result = ex_a + ex_b;
			alu_subf: alu_result = ex_b + ~ex_a + `PU_WORD_W'(1);
			alu_or:   alu_result = ex_a | ex_b;
			alu_and:  alu_result = ex_a & ex_b;
			alu_xor:  alu_result = ex_a ^ ex_b;
			default:  alu_result = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_valid <= 1'b0;
		end else if (!stall) begin
			wb_valid <= ex_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall && ex_valid) begin
			wb_dest <= ex_dest;
			wb_data <= alu_result;
		end
	end

	// write once, on the edge where the outside consumes the result
	assign gpr_we = wb_valid && !stall;

	a_wb_hold: assert property (
		@(posedge clk) disable iff (!rst_n)
		(wb_valid && stall) |=> wb_valid && $stable(wb_data) && $stable(wb_dest)
	) else $error("write-back result changed while stalled");

endmodule

// ==== hdl/decode.sv ====
// record forms and oe variants are treated as unknown and dropped like nops
`timescale 1ns/1ps
`include "pu_macros.svh"

module decode
	import pu_types_pkg::*;
	import pu_inst_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  logic     inst_valid,
	input  inst_t    inst,
	output logic     inst_ready,
	input  logic     stall,
	output gpr_sel_t gpr_sel_a,
	output gpr_sel_t gpr_sel_b,
	input  word_t    gpr_a,
	input  word_t    gpr_b,
	input  word_t    alu_result,
	output logic     ex_valid,
	output alu_op_t  ex_op,
	output word_t    ex_a,
	output word_t    ex_b,
	output gpr_sel_t ex_dest
);

	opcd_t      f_opcd;
	gpr_sel_t   f_rt;
	gpr_sel_t   f_ra;
	gpr_sel_t   f_rb;
	imm_t       f_imm;
	logic [9:0] f_xo;
	logic       f_rc;

	logic     legal;
	logic     is_nop;
	logic     accept;
	logic     use_imm;
	logic     zero_a;
	alu_op_t  op;
	gpr_sel_t sel_a;
	gpr_sel_t sel_b;
	gpr_sel_t dest;
	word_t    imm_ext;
	word_t    fwd_a;
	word_t    fwd_b;

	assign f_opcd = opcd_t'(inst[31:26]);
	assign f_rt   = inst[25:21];
	assign f_ra   = inst[20:16];
	assign f_rb   = inst[15:11];
	assign f_imm  = inst[15:0];
	assign f_xo   = inst[10:1];
	assign f_rc   = inst[0];

	// ori 0,0,0
	assign is_nop = (inst == {op_ori, 26'd0});

	always_comb begin
		legal   = 1'b0;
		op      = alu_add;
		sel_a   = f_ra;
		sel_b   = f_rb;
		dest    = f_rt;
		use_imm = 1'b1;
		zero_a  = 1'b0;
		imm_ext = {{(`PU_WORD_W-`PU_IMM_W){f_imm[`PU_IMM_W-1]}}, f_imm};
		case (f_opcd)
			op_addi: begin
				legal  = 1'b1;
				zero_a = (f_ra == '0);
			end
			op_addis: begin
				legal   = 1'b1;
				zero_a  = (f_ra == '0);
				imm_ext = {f_imm, {(`PU_WORD_W-`PU_IMM_W){1'b0}}};
			end
			op_ori: begin
				// source is rs in the rt field, result goes to ra
				legal   = 1'b1;
				op      = alu_or;
				sel_a   = f_rt;
				dest    = f_ra;
				imm_ext = {{(`PU_WORD_W-`PU_IMM_W){1'b0}}, f_imm};
			end
			op_alu_xo: begin
				use_imm = 1'b0;
				legal   = !f_rc;
				case (f_xo)
					xo_add:  op = alu_add;
					xo_subf: op = alu_subf;
					xo_or:   op = alu_or;
					xo_and:  op = alu_and;
					xo_xor:  op = alu_xor;
					default: legal = 1'b0;
				endcase
				// logical X-forms read rs and write ra
				if (f_xo == xo_or || f_xo == xo_and || f_xo == xo_xor) begin
					sel_a = f_rt;
					dest  = f_ra;
				end
			end
			default: legal = 1'b0;
		endcase
	end

	assign gpr_sel_a = sel_a;
	assign gpr_sel_b = sel_b;

	// only the execute stage needs forwarding, write-back is bypassed in the register file
	assign fwd_a = (ex_valid && ex_dest == sel_a) ? alu_result : gpr_a;
	assign fwd_b = (ex_valid && ex_dest == sel_b) ? alu_result : gpr_b;

	assign inst_ready = !stall;
	assign accept     = inst_valid && inst_ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_valid <= 1'b0;
		end else if (!stall) begin
			ex_valid <= accept && legal && !is_nop;
		end
	end

	// payload only moves for real instructions, dropped ones leave it untouched
	always_ff @(posedge clk) begin
		if (accept && legal && !is_nop) begin
			ex_op   <= op;
			ex_a    <= zero_a ? '0 : fwd_a;
			ex_b    <= use_imm ? imm_ext : fwd_b;
			ex_dest <= dest;
		end
	end

	// nop taken from the port encoding, ori with rs, ra and ui all zero
	a_nop_dropped: assert property (
		@(posedge clk) disable iff (!rst_n)
		(inst_valid && inst_ready && inst[31:26] == op_ori && inst[25:0] == '0)
			|=> !ex_valid
	) else $error("nop reached the execute stage");

	a_ex_hold: assert property (
		@(posedge clk) disable iff (!rst_n)
		stall |=> $stable(ex_valid) && (!ex_valid || $stable({ex_op, ex_a, ex_b, ex_dest}))
	) else $error("execute register moved under stall");

endmodule

// ==== hdl/register_file.sv ====
// all registers reset to zero; a same-cycle write is visible on both read ports
`timescale 1ns/1ps
`include "pu_macros.svh"

module register_file
	import pu_types_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  gpr_sel_t gpr_sel_a,
	input  gpr_sel_t gpr_sel_b,
	output word_t    gpr_a,
	output word_t    gpr_b,
	input  logic     gpr_we,
	input  gpr_sel_t gpr_dest,
	input  word_t    gpr_data
);

	word_t regs [`PU_GPR_N];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `PU_GPR_N; i++) begin
				regs[i] <= '0;
			end
		end else if (gpr_we) begin
			regs[gpr_dest] <= gpr_data;
		end
	end

	// write-through so decode sees the write-back stage result
	assign gpr_a = (gpr_we && gpr_dest == gpr_sel_a) ? gpr_data : regs[gpr_sel_a];
	assign gpr_b = (gpr_we && gpr_dest == gpr_sel_b) ? gpr_data : regs[gpr_sel_b];

	// the write-back stage must stay quiet while the core is in reset
	a_no_write_in_reset: assert property (
		@(posedge clk) !rst_n |-> !gpr_we
	) else $error("register write requested during reset");

endmodule

// ==== hdl/pu_inst_pkg.sv ====
// only the opcodes of the supported subset are listed; everything else decodes as unknown

package pu_inst_pkg;

	// primary opcodes
	typedef enum logic [5:0] {
		op_addi   = 6'd14,
		op_addis  = 6'd15,
		op_ori    = 6'd24,
		op_alu_xo = 6'd31
	} opcd_t;

	// extended opcodes under op_alu_xo, compared against inst[10:1]
	// an oe bit set in inst[10] makes add/subf unmatched
	localparam logic [9:0] xo_add  = 10'd266;
	localparam logic [9:0] xo_subf = 10'd40;
	localparam logic [9:0] xo_or   = 10'd444;
	localparam logic [9:0] xo_and  = 10'd28;
	localparam logic [9:0] xo_xor  = 10'd316;

	// ALU operations
	// alu_subf computes b - a as in the architecture
	typedef enum logic [2:0] {
		alu_add,
		alu_subf,
		alu_or,
		alu_and,
		alu_xor
	} alu_op_t;

endpackage

// ==== hdl/pu_types_pkg.sv ====
// plain vector types only; field slicing of inst_t is done by the decoder
`include "pu_macros.svh"

package pu_types_pkg;

	// one data word as held in a register
	typedef logic [`PU_WORD_W-1:0] word_t;

	// register number, r0 is a real register except for addi/addis ra
	typedef logic [`PU_GPR_SEL_W-1:0] gpr_sel_t;

	// D-form immediate before expansion
	typedef logic [`PU_IMM_W-1:0] imm_t;

	// raw instruction word
	// opcd [31:26], rt [25:21], ra [20:16], rb [15:11]
	// d/si/ui [15:0], xo [10:1], rc [0]
	typedef logic [`PU_INST_W-1:0] inst_t;

endpackage

// ==== hdl/pu_macros.svh ====
// widths are fixed by the instruction encoding; changing PU_WORD_W alone breaks immediates
`ifndef PU_MACROS_SVH
`define PU_MACROS_SVH

// data path word width
`define PU_WORD_W 32

// number of general purpose registers
`define PU_GPR_N 32

// bits needed to select one register
`define PU_GPR_SEL_W 5

// immediate field width of the D-form
`define PU_IMM_W 16

// instruction word width, big-endian field layout
`define PU_INST_W 32

`endif
